// ==== verilog/pdpIsaPkg.sv ====
// PDP-8 bit 0 is the MSB, so PDP-8 bit n sits at index 11-n; 4K words only, no memory fields
package pdpIsaPkg;

	typedef logic [11:0] pdpWord_t;                 // One machine word
	typedef logic [11:0] pdpAddr_t;                 // Field 0 only

	// Major opcode, PDP-8 bits 0..2
	typedef enum logic [2:0] {
		OP_AND = 3'd0,
		OP_TAD = 3'd1,
		OP_ISZ = 3'd2,
		OP_DCA = 3'd3,
		OP_JMS = 3'd4,
		OP_JMP = 3'd5,
		OP_IOT = 3'd6,                          // Retires as a no-op here
		OP_OPR = 3'd7
	} pdpOpcode_e;

	typedef enum logic [1:0] {
		MICRO_GRP1,                             // Bit 3 low
		MICRO_GRP2,                             // Bit 3 high, bit 11 low
		MICRO_GRP3                              // Bit 3 high, bit 11 high
	} pdpMicroGroup_e;

	// Group 1 rotate field is PDP-8 bits 8..10 (RAR, RAL, twice)
	typedef enum logic [2:0] {
		ROT_NONE = 3'b000,
		ROT_RAL  = 3'b010,
		ROT_RTL  = 3'b011,
		ROT_RAR  = 3'b100,
		ROT_RTR  = 3'b101
	} pdpRotate_e;

	typedef struct packed {
		pdpOpcode_e opcode;
		logic       indirect;                   // I bit
		logic       curPage;                    // M bit, page zero when low
		logic [6:0] offset;
	} pdpInstr_t;

	typedef struct packed {
		pdpInstr_t instr;
		pdpAddr_t  pc;
	} pdpFetched_t;

	typedef struct packed {
		pdpInstr_t instr;
		pdpAddr_t  pc;
		pdpAddr_t  ea;                          // Final operand address
	} pdpDecoded_t;

	// Indirect through these locations pre-increments the pointer
	localparam pdpAddr_t AUTO_INDEX_LO = 12'o10;
	localparam pdpAddr_t AUTO_INDEX_HI = 12'o17;

endpackage

// ==== verilog/pdpBusPkg.sv ====
// Memory side types; the APB data path is one 12-bit word wide with no strobes or error response
package pdpBusPkg;
	import pdpIsaPkg::*;

	// Who owns the transfer in flight
	typedef enum logic [1:0] {
		MEM_FETCH,                              // Instruction word
		MEM_INDIRECT,                           // Pointer read or auto-index write-back
		MEM_READ,                               // Operand read
		MEM_WRITE                               // Operand write
	} pdpMemKind_e;

	typedef struct packed {
		logic     valid;                        // Held until the done pulse
		logic     write;
		pdpAddr_t addr;
		pdpWord_t wdata;
	} pdpMemReq_t;

	typedef struct packed {
		logic     psel;
		logic     penable;
		logic     pwrite;
		pdpAddr_t paddr;
		pdpWord_t pwdata;
	} pdpApbReq_t;

	typedef struct packed {
		pdpWord_t prdata;
		logic     pready;
	} pdpApbRsp_t;

endpackage

// ==== verilog/pdpApbMaster.sv ====
`timescale 1ns/1ps
// One transfer at a time, fixed priority with no fairness; requests seen during a done pulse wait
module pdpApbMaster
	import pdpIsaPkg::*;
	import pdpBusPkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst,
	input  pdpMemReq_t i_fetchReq,
	input  pdpMemReq_t i_addrReq,
	input  pdpMemReq_t i_execReq,
	output logic       o_fetchDone,
	output logic       o_addrDone,
	output logic       o_execDone,
	output pdpWord_t   o_rdata,
	output pdpApbReq_t o_apb,
	input  pdpApbRsp_t i_apb
);
	typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS} apbState_e;

	apbState_e   state;
	pdpMemKind_e kind;                              // Owner of current transfer
	logic        doneQ;
	logic        xferWrite;
	pdpAddr_t    xferAddr;
	pdpWord_t    xferData;
	pdpMemReq_t  pick;
	pdpMemKind_e pickKind;
	logic        grant;

	// Execute first, then address generation, then fetch
	always_comb begin
		pick     = i_fetchReq;
		pickKind = MEM_FETCH;
		if (i_execReq.valid) begin
			pick     = i_execReq;
			pickKind = i_execReq.write ? MEM_WRITE : MEM_READ;
		end else if (i_addrReq.valid) begin
			pick     = i_addrReq;
			pickKind = MEM_INDIRECT;                // Write-back counts here too
		end
	end

	assign grant = (state == ST_IDLE) && pick.valid && !doneQ;    // Skip the done cycle

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= ST_IDLE;
			kind  <= MEM_FETCH;
			doneQ <= 1'b0;
		end else begin
			doneQ <= 1'b0;
			case (state)
				ST_IDLE: if (grant) begin
					state <= ST_SETUP;
					kind  <= pickKind;
				end
				ST_SETUP: state <= ST_ACCESS;
				ST_ACCESS: if (i_apb.pready) begin
					state <= ST_IDLE;                   // psel drops for at least one cycle
					doneQ <= 1'b1;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Transfer payload and read capture
	always_ff @(posedge i_clk) begin
		if (grant) begin
			xferWrite <= pick.write;
			xferAddr  <= pick.addr;
			xferData  <= pick.wdata;
		end
		if (state == ST_ACCESS && i_apb.pready)
			o_rdata <= i_apb.prdata;
	end

	always_comb begin
		o_apb.psel    = (state != ST_IDLE);
		o_apb.penable = (state == ST_ACCESS);
		o_apb.pwrite  = xferWrite;
		o_apb.paddr   = xferAddr;
		o_apb.pwdata  = xferData;
	end

	assign o_fetchDone = doneQ && (kind == MEM_FETCH);
	assign o_addrDone  = doneQ && (kind == MEM_INDIRECT);
	assign o_execDone  = doneQ && (kind == MEM_READ || kind == MEM_WRITE);

	//*******************************************************************
	// Protocol checks
	//*******************************************************************
	penableAfterSetup: assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(o_apb.penable) |-> $past(o_apb.psel && !o_apb.penable));

	stableWhileWaiting: assert property (@(posedge i_clk) disable iff (i_rst)
		o_apb.penable && !i_apb.pready |=>
			$stable(o_apb.paddr) && $stable(o_apb.pwrite) && $stable(o_apb.pwdata));

endmodule

// ==== verilog/pdpFetch.sv ====
`timescale 1ns/1ps
// Fetches exactly one word per redirect; a redirect must not arrive while an instruction is held
module pdpFetch
	import pdpIsaPkg::*;
	import pdpBusPkg::*;
#(
	parameter pdpAddr_t RESET_PC = 12'o200
) (
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic        i_redirect,
	input  pdpAddr_t    i_nextPc,
	output pdpMemReq_t  o_memReq,
	input  logic        i_memDone,
	input  pdpWord_t    i_rdata,
	output logic        o_valid,
	output pdpFetched_t o_fetched,
	input  logic        i_ready
);
	typedef enum logic [1:0] {F_WAIT, F_FETCH, F_HOLD} fetchState_e;

	fetchState_e state;
	pdpAddr_t    pc;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= F_FETCH;                       // Start fetching right away
			pc    <= RESET_PC;
		end else begin
			case (state)
				F_WAIT: if (i_redirect) begin
					pc    <= i_nextPc;
					state <= F_FETCH;
				end
				F_FETCH: if (i_memDone) state <= F_HOLD;
				F_HOLD:  if (i_ready) state <= F_WAIT;    // Wait for the retire pulse
				default: state <= F_WAIT;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == F_FETCH && i_memDone) begin
			o_fetched.instr <= pdpInstr_t'(i_rdata);
			o_fetched.pc    <= pc;
		end
	end

	always_comb begin
		o_memReq.valid = (state == F_FETCH);
		o_memReq.write = 1'b0;                      // Read only
		o_memReq.addr  = pc;
		o_memReq.wdata = '0;
	end

	assign o_valid = (state == F_HOLD);

	// Execute redirects only after the held word has moved on
	noRedirectWhileHeld: assert property (@(posedge i_clk) disable iff (i_rst)
		i_redirect |-> !o_valid);

endmodule

// ==== verilog/pdpAddrGen.sv ====
`timescale 1ns/1ps
// Auto-index applies to any indirect pointer at absolute 0o10..0o17, also from page zero code
module pdpAddrGen
	import pdpIsaPkg::*;
	import pdpBusPkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic        i_valid,
	input  pdpFetched_t i_fetched,
	output logic        o_ready,
	output pdpMemReq_t  o_memReq,
	input  logic        i_memDone,
	input  pdpWord_t    i_rdata,
	output logic        o_valid,
	output pdpDecoded_t o_decoded,
	input  logic        i_ready
);
	typedef enum logic [1:0] {A_IDLE, A_PTR, A_INC, A_HOLD} addrState_e;

	addrState_e state;
	pdpAddr_t   ptrAddr;                            // Pointer location for indirect words
	pdpAddr_t   direct;
	logic       noOperand;
	logic       autoIndex;

	// Page zero or current page
	assign direct = i_fetched.instr.curPage ? {i_fetched.pc[11:7], i_fetched.instr.offset}
	                                        : {5'b0, i_fetched.instr.offset};
	assign noOperand = (i_fetched.instr.opcode == OP_OPR) || (i_fetched.instr.opcode == OP_IOT);
	assign autoIndex = (ptrAddr >= AUTO_INDEX_LO) && (ptrAddr <= AUTO_INDEX_HI);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= A_IDLE;
		end else begin
			case (state)
				A_IDLE: if (i_valid) begin
					if (i_fetched.instr.indirect && !noOperand)
						state <= A_PTR;                 // JMP I takes this path too
					else
						state <= A_HOLD;                // Direct, one cycle
				end
				A_PTR: if (i_memDone) state <= autoIndex ? A_INC : A_HOLD;
				A_INC: if (i_memDone) state <= A_HOLD;
				A_HOLD: if (i_ready) state <= A_IDLE;
				default: state <= A_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == A_IDLE && i_valid) begin
			o_decoded.instr <= i_fetched.instr;
			o_decoded.pc    <= i_fetched.pc;
			o_decoded.ea    <= direct;
			ptrAddr         <= direct;
		end
		if (state == A_PTR && i_memDone)
			o_decoded.ea <= autoIndex ? pdpAddr_t'(i_rdata + 12'd1) : i_rdata;    // Pre-increment
	end

	// Pointer read, then incremented pointer written back
	always_comb begin
		o_memReq.valid = (state == A_PTR) || (state == A_INC);
		o_memReq.write = (state == A_INC);
		o_memReq.addr  = ptrAddr;
		o_memReq.wdata = o_decoded.ea;
	end

	assign o_ready = (state == A_IDLE);
	assign o_valid = (state == A_HOLD);

endmodule

// ==== verilog/pdpMicroOps.sv ====
`timescale 1ns/1ps
// Purely combinational; non-OPR words and group 3 return inputs unchanged, BSW is not decoded
module pdpMicroOps
	import pdpIsaPkg::*;
(
	input  pdpInstr_t i_instr,
	input  pdpWord_t  i_acc,
	input  logic      i_link,
	input  pdpWord_t  i_switchReg,
	output pdpWord_t  o_acc,
	output logic      o_link,
	output logic      o_skip,
	output logic      o_halt
);
	logic [11:0]    ir;                             // Raw bits, PDP-8 bit n at [11-n]
	pdpMicroGroup_e group;
	logic [12:0]    lac;                            // Link and accumulator as one value
	logic           orHit;

	assign ir = i_instr;

	always_comb begin
		if (!ir[8])
			group = MICRO_GRP1;
		else if (!ir[0])
			group = MICRO_GRP2;
		else
			group = MICRO_GRP3;
	end

	// Group 2 skip conditions, sampled before any clear
	assign orHit = (ir[6] && i_acc[11])                    // SMA
	            || (ir[5] && (i_acc == 12'o0))              // SZA
	            || (ir[4] && i_link);                      // SNL

	always_comb begin
		o_acc  = i_acc;
		o_link = i_link;
		o_skip = 1'b0;
		o_halt = 1'b0;
		lac    = {i_link, i_acc};
		if (i_instr.opcode == OP_OPR) begin
			case (group)
				//*******************************************************
				// Group 1, in sequence
				//*******************************************************
				MICRO_GRP1: begin
					if (ir[7]) lac[11:0] = '0;          // CLA
					if (ir[6]) lac[12] = 1'b0;          // CLL
					if (ir[5]) lac[11:0] = ~lac[11:0];  // CMA
					if (ir[4]) lac[12] = ~lac[12];      // CML
					lac = lac + {12'b0, ir[0]};         // IAC, carry flips the link
					case (pdpRotate_e'(ir[3:1]))
						ROT_RAR: lac = {lac[0], lac[12:1]};
						ROT_RTR: lac = {lac[1:0], lac[12:2]};
						ROT_RAL: lac = {lac[11:0], lac[12]};
						ROT_RTL: lac = {lac[10:0], lac[12:11]};
						default: lac = lac;             // No rotate
					endcase
					{o_link, o_acc} = lac;
				end
				//*******************************************************
				// Group 2, skip then CLA, OSR, HLT
				//*******************************************************
				MICRO_GRP2: begin
					o_skip = ir[3] ? !orHit : orHit;    // Bit 8 picks the AND group
					if (ir[7]) o_acc = '0;
					if (ir[2]) o_acc = o_acc | i_switchReg;
					o_halt = ir[1];
				end
				default: o_acc = i_acc;                 // Group 3, no MQ here
			endcase
		end
	end

endmodule

// ==== verilog/pdpExecute.sv ====
`timescale 1ns/1ps
// Halt is sticky until reset; IOT words only advance the PC
module pdpExecute
	import pdpIsaPkg::*;
	import pdpBusPkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic        i_valid,
	input  pdpDecoded_t i_decoded,
	output logic        o_ready,
	output pdpMemReq_t  o_memReq,
	input  logic        i_memDone,
	input  pdpWord_t    i_rdata,
	input  pdpWord_t    i_switchReg,
	output logic        o_redirect,
	output pdpAddr_t    o_nextPc,
	output pdpWord_t    o_acc,
	output logic        o_link,
	output logic        o_halted
);
	typedef enum logic [1:0] {X_IDLE, X_READ, X_WRITE} execState_e;

	execState_e  state;
	pdpDecoded_t cur;
	pdpWord_t    wdataQ;                            // Store data, also the ISZ result
	pdpAddr_t    inPcNext;
	logic        accept;
	pdpWord_t    microAcc;
	logic        microLink, microSkip, microHalt;

	pdpMicroOps microOps_inst (
		.i_instr    (i_decoded.instr),
		.i_acc      (o_acc),
		.i_link     (o_link),
		.i_switchReg(i_switchReg),
		.o_acc      (microAcc),
		.o_link     (microLink),
		.o_skip     (microSkip),
		.o_halt     (microHalt)
	);

	assign o_ready  = (state == X_IDLE) && !o_halted;
	assign accept   = i_valid && o_ready;
	assign inPcNext = i_decoded.pc + 12'd1;

	//*******************************************************************
	// Architectural state and sequencing
	//*******************************************************************
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state      <= X_IDLE;
			o_acc      <= '0;
			o_link     <= 1'b0;
			o_halted   <= 1'b0;
			o_redirect <= 1'b0;
		end else begin
			o_redirect <= 1'b0;                     // One-cycle retire pulse
			case (state)
				X_IDLE: if (accept) begin
					case (i_decoded.instr.opcode)
						OP_AND, OP_TAD, OP_ISZ: state <= X_READ;
						OP_DCA, OP_JMS:         state <= X_WRITE;
						OP_OPR: begin
							o_acc      <= microAcc;
							o_link     <= microLink;
							o_halted   <= microHalt;
							o_redirect <= !microHalt;   // No further fetch after HLT
						end
						default: o_redirect <= 1'b1;    // JMP and IOT
					endcase
				end
				X_READ: if (i_memDone) begin
					case (cur.instr.opcode)
						OP_AND: o_acc <= o_acc & i_rdata;
						OP_TAD: {o_link, o_acc} <= {o_link, o_acc} + {1'b0, i_rdata};
						default: o_acc <= o_acc;         // ISZ writes back next
					endcase
					state      <= (cur.instr.opcode == OP_ISZ) ? X_WRITE : X_IDLE;
					o_redirect <= (cur.instr.opcode != OP_ISZ);
				end
				X_WRITE: if (i_memDone) begin
					if (cur.instr.opcode == OP_DCA) o_acc <= '0;
					state      <= X_IDLE;
					o_redirect <= 1'b1;
				end
				default: state <= X_IDLE;
			endcase
		end
	end

	// Held instruction, store data and next PC
	always_ff @(posedge i_clk) begin
		if (accept) begin
			cur <= i_decoded;
			case (i_decoded.instr.opcode)
				OP_JMP:  o_nextPc <= i_decoded.ea;
				OP_OPR:  o_nextPc <= inPcNext + {11'b0, microSkip};
				default: o_nextPc <= inPcNext;
			endcase
			wdataQ <= (i_decoded.instr.opcode == OP_JMS) ? inPcNext : o_acc;    // Return or DCA
		end
		if (state == X_READ && i_memDone)
			wdataQ <= i_rdata + 12'd1;                  // ISZ
		if (state == X_WRITE && i_memDone) begin
			if (cur.instr.opcode == OP_JMS)
				o_nextPc <= cur.ea + 12'd1;             // Body starts after the return slot
			else if (cur.instr.opcode == OP_ISZ && wdataQ == 12'o0)
				o_nextPc <= cur.pc + 12'd2;
		end
	end

	always_comb begin
		o_memReq.valid = (state == X_READ) || (state == X_WRITE);
		o_memReq.write = (state == X_WRITE);
		o_memReq.addr  = cur.ea;
		o_memReq.wdata = wdataQ;
	end

endmodule

// ==== verilog/pdpCore.sv ====
`timescale 1ns/1ps
// One instruction in flight at a time; memory is external and reached only over APB
module pdpCore
	import pdpIsaPkg::*;
	import pdpBusPkg::*;
#(
	parameter pdpAddr_t RESET_PC = 12'o200
) (
	input  logic       i_clk,
	input  logic       i_rst,
	input  pdpWord_t   i_switchReg,
	output pdpApbReq_t o_apb,
	input  pdpApbRsp_t i_apb,
	output pdpWord_t   o_acc,
	output logic       o_link,
	output logic       o_halted
);
	pdpMemReq_t  fetchReq, addrReq, execReq;
	logic        fetchDone, addrDone, execDone;
	pdpWord_t    rdata;                             // Shared read return
	logic        fetchValid, addrReady;
	pdpFetched_t fetched;
	logic        decValid, execReady;
	pdpDecoded_t decoded;
	logic        redirect;
	pdpAddr_t    nextPc;

	//*******************************************************************
	// Stages
	//*******************************************************************
	pdpFetch #(.RESET_PC(RESET_PC)) fetch_inst (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_redirect(redirect),
		.i_nextPc  (nextPc),
		.o_memReq  (fetchReq),
		.i_memDone (fetchDone),
		.i_rdata   (rdata),
		.o_valid   (fetchValid),
		.o_fetched (fetched),
		.i_ready   (addrReady)
	);

	pdpAddrGen addrGen_inst (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_valid  (fetchValid),
		.i_fetched(fetched),
		.o_ready  (addrReady),
		.o_memReq (addrReq),
		.i_memDone(addrDone),
		.i_rdata  (rdata),
		.o_valid  (decValid),
		.o_decoded(decoded),
		.i_ready  (execReady)
	);

	pdpExecute execute_inst (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_valid    (decValid),
		.i_decoded  (decoded),
		.o_ready    (execReady),
		.o_memReq   (execReq),
		.i_memDone  (execDone),
		.i_rdata    (rdata),
		.i_switchReg(i_switchReg),
		.o_redirect (redirect),       // Retire pulse back to fetch
		.o_nextPc   (nextPc),
		.o_acc      (o_acc),
		.o_link     (o_link),
		.o_halted   (o_halted)
	);

	pdpApbMaster apbMaster_inst (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_fetchReq (fetchReq),
		.i_addrReq  (addrReq),
		.i_execReq  (execReq),
		.o_fetchDone(fetchDone),
		.o_addrDone (addrDone),
		.o_execDone (execDone),
		.o_rdata    (rdata),
		.o_apb      (o_apb),
		.i_apb      (i_apb)
	);

endmodule

// ==== dv/pdpApbMemory.sv ====
`timescale 1ns/1ps
// Simulation-only APB completer; wait states are drawn once per transfer, in its setup cycle
module pdpApbMemory
	import pdpIsaPkg::*;
	import pdpBusPkg::*;
#(
	parameter int SEED = 32'hc4741a4f
) (
	input  logic       i_clk,
	input  logic       i_rst,
	input  int         i_maxWait,                   // Upper bound of wait states per access
	input  pdpApbReq_t i_apbReq,
	output pdpApbRsp_t o_apbRsp
);
	pdpWord_t mem [0:4095];                         // Full 4K field, backdoor visible
	int       waitCnt;                              // Access cycles still to stall
	int       seed;
	logic     lastCycle;                            // Access phase completes this cycle

	initial seed = SEED;

	assign lastCycle = i_apbReq.psel && i_apbReq.penable && (waitCnt == 0);

	always @(posedge i_clk) begin
		if (i_rst) begin
			waitCnt <= 0;
		end else if (i_apbReq.psel && !i_apbReq.penable) begin
			// Setup cycle picks the stall length
			if (i_maxWait > 0)
				waitCnt <= $unsigned($random(seed)) % (i_maxWait + 1);
			else
				waitCnt <= 0;
		end else if (i_apbReq.psel && waitCnt > 0) begin
			waitCnt <= waitCnt - 1;
		end
		if (lastCycle && i_apbReq.pwrite)
			mem[i_apbReq.paddr] <= i_apbReq.pwdata;     // Write lands with pready
	end

	assign o_apbRsp.pready = lastCycle;
	assign o_apbRsp.prdata = mem[i_apbReq.paddr];     // Read data is combinational

endmodule

// ==== dv/pdpCoreTb.sv ====
`timescale 1ns/1ps
// Directed tests with programs placed at a 0o200 reset PC; memory is loaded and read by backdoor
module pdpCoreTb
	import pdpIsaPkg::*;
	import pdpBusPkg::*;
();
	localparam pdpAddr_t RESET_PC    = 12'o200;
	localparam int       SEED        = 32'hc4741a4f;
	localparam int       RUN_TIMEOUT = 20000;       // Cycles allowed until HLT
	localparam int       BUS_TIMEOUT = 50;          // Cycles allowed until first psel
	localparam int       WAIT_NORMAL = 3;
	localparam int       WAIT_LONG   = 15;

	logic       clk;
	logic       rst;
	pdpWord_t   switchReg;
	int         maxWait;
	pdpApbReq_t apbReq;
	pdpApbRsp_t apbRsp;
	pdpWord_t   acc;
	logic       link;
	logic       halted;
	int         seed;
	int         checks;
	int         errors;
	int         timeouts;
	int         cycles;

	pdpCore #(.RESET_PC(RESET_PC)) pdpCore_inst (
		.i_clk      (clk),
		.i_rst      (rst),
		.i_switchReg(switchReg),
		.o_apb      (apbReq),
		.i_apb      (apbRsp),
		.o_acc      (acc),
		.o_link     (link),
		.o_halted   (halted)
	);

	pdpApbMemory #(.SEED(SEED)) memory_inst (
		.i_clk    (clk),
		.i_rst    (rst),
		.i_maxWait(maxWait),
		.i_apbReq (apbReq),
		.o_apbRsp (apbRsp)
	);

	always #5 clk = ~clk;                           // 10 ns period

	//********************************************************************
	// Compare tasks
	//********************************************************************
	task automatic compareWord(input string what, input pdpWord_t got, input pdpWord_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at time %0t: %s is %04o, expected %04o", $time, what, got, exp);
		end
	endtask

	task automatic compareBit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	//********************************************************************
	// Reference rules for the microinstructions
	//********************************************************************
	// Group 1 order: clears, complements, IAC, then rotate once or twice
	function automatic logic [12:0] group1Expect(input pdpWord_t uop, input pdpWord_t accIn,
	                                             input logic linkIn);
		pdpWord_t a;
		logic     l;
		logic     out;
		int       turns;
		int       n;
		a = accIn;
		l = linkIn;
		if (uop & 12'o0200) a = '0;                 // CLA
		if (uop & 12'o0100) l = 1'b0;               // CLL
		if (uop & 12'o0040) a = ~a;                 // CMA
		if (uop & 12'o0020) l = ~l;                 // CML
		if (uop & 12'o0001) begin                   // IAC, overflow flips the link
			if (a == 12'o7777) l = ~l;
			a = a + 12'd1;
		end
		turns = (uop & 12'o0002) ? 2 : 1;
		for (n = 0; n < turns; n++) begin
			if (uop & 12'o0010) begin               // Right through the link
				out = a[0];
				a   = {l, a[11:1]};
				l   = out;
			end else if (uop & 12'o0004) begin      // Left through the link
				out = a[11];
				a   = {a[10:0], l};
				l   = out;
			end
		end
		return {l, a};
	endfunction

	// OR group skips on any hit, AND group needs every inverse test
	function automatic logic group2Skip(input pdpWord_t uop, input pdpWord_t accIn,
	                                    input logic linkIn);
		logic minus;
		logic zero;
		logic linkSet;
		minus   = (uop & 12'o0100) != 0;
		zero    = (uop & 12'o0040) != 0;
		linkSet = (uop & 12'o0020) != 0;
		if ((uop & 12'o0010) == 0)
			return (minus && accIn[11]) || (zero && accIn == 12'o0) || (linkSet && linkIn);
		return (!minus || !accIn[11]) && (!zero || accIn != 12'o0) && (!linkSet || !linkIn);
	endfunction

	function automatic pdpWord_t group2Acc(input pdpWord_t uop, input pdpWord_t accIn,
	                                       input pdpWord_t sw);
		pdpWord_t a;
		a = (uop & 12'o0200) ? 12'o0 : accIn;      // CLA after the skip test
		if (uop & 12'o0004) a = a | sw;             // OSR
		return a;
	endfunction

	function automatic pdpWord_t fillWord(input pdpAddr_t a);
		return a ^ 12'o5252;
	endfunction

	//********************************************************************
	// Program loading and run control
	//********************************************************************
	task automatic loadWord(input pdpAddr_t addr, input pdpWord_t word);
		memory_inst.mem[addr] = word;
	endtask

	// Puts the core in reset and fills memory with an address pattern
	task automatic beginProgram(input int waitStates);
		int a;
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);                             // Bus idle from here on
		maxWait = waitStates;
		for (a = 0; a < 4096; a++)
			loadWord(pdpAddr_t'(a), fillWord(pdpAddr_t'(a)));
	endtask

	task automatic startCore();
		repeat (16) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic waitHalted(input string name, output int count);
		count = 0;
		while (!halted && count < RUN_TIMEOUT) begin
			@(negedge clk);
			count++;
		end
		if (!halted) begin
			timeouts++;
			$display("Timeout: the %s program did not halt within %0d cycles", name, RUN_TIMEOUT);
		end
	endtask

	// Shared shape for both microinstruction groups; ISZ at 0o204 marks no skip
	task automatic loadMicroProgram(input pdpWord_t uop, input pdpWord_t accIn, input logic linkIn);
		loadWord(12'o200, 12'o7300);                // CLA CLL
		loadWord(12'o201, 12'o1250);                // TAD 250
		loadWord(12'o202, linkIn ? 12'o7020 : 12'o7000);    // CML or NOP
		loadWord(12'o203, uop);
		loadWord(12'o204, 12'o2252);                // ISZ 252
		loadWord(12'o205, 12'o7402);                // HLT
		loadWord(12'o250, accIn);
		loadWord(12'o252, 12'o0000);
	endtask

	//********************************************************************
	// Directed tests
	//********************************************************************
	task automatic testReset();
		int count;
		beginProgram(WAIT_NORMAL);
		loadWord(RESET_PC, 12'o7402);               // HLT only
		repeat (16) @(negedge clk);
		compareBit("o_halted in reset", halted, 1'b0);
		compareBit("psel in reset", apbReq.psel, 1'b0);
		compareBit("penable in reset", apbReq.penable, 1'b0);
		rst = 1'b0;
		count = 0;
		while (!apbReq.psel && count < BUS_TIMEOUT) begin
			@(negedge clk);
			count++;
		end
		if (!apbReq.psel) begin
			timeouts++;
			$display("Timeout: no APB transfer started after reset");
		end
		compareBit("fetch on first clock after reset", count == 1, 1'b1);
		compareWord("first APB address", apbReq.paddr, RESET_PC);
		compareBit("penable in setup cycle", apbReq.penable, 1'b0);
		waitHalted("reset", count);
		compareBit("o_halted after HLT", halted, 1'b1);
	endtask

	task automatic testArithmetic(input string name, input int waitStates, output int count);
		pdpWord_t    v1;
		pdpWord_t    v2;
		pdpWord_t    v3;
		logic [12:0] sum;
		v1 = 12'o6543;
		v2 = 12'o3770;
		v3 = 12'o5432;
		beginProgram(waitStates);
		loadWord(12'o200, 12'o7320);                // CLA CLL CML, link starts set
		loadWord(12'o201, 12'o1250);                // TAD 250
		loadWord(12'o202, 12'o0251);                // AND 251
		loadWord(12'o203, 12'o1252);                // TAD 252
		loadWord(12'o204, 12'o3253);                // DCA 253
		loadWord(12'o205, 12'o1252);                // TAD 252 into a clear acc
		loadWord(12'o206, 12'o7402);
		loadWord(12'o250, v1);
		loadWord(12'o251, v2);
		loadWord(12'o252, v3);
		startCore();
		waitHalted(name, count);
		sum = {1'b0, v1 & v2} + {1'b0, v3};
		compareWord({name, " stored word"}, memory_inst.mem[12'o253], sum[11:0]);
		compareWord({name, " acc"}, acc, v3);
		compareBit({name, " link"}, link, 1'b1 ^ sum[12]);    // Carry complements
	endtask

	task automatic testAddressing();
		logic [12:0] sum;
		int          count;
		beginProgram(WAIT_NORMAL);
		loadWord(12'o200, 12'o7300);
		loadWord(12'o201, 12'o1050);                // TAD 50, page zero
		loadWord(12'o202, 12'o1660);                // TAD I 260, current page pointer
		loadWord(12'o203, 12'o1410);                // TAD I 10, auto-index
		loadWord(12'o204, 12'o1410);
		loadWord(12'o205, 12'o3417);                // DCA I 17
		loadWord(12'o206, 12'o1261);                // TAD 261, current page
		loadWord(12'o207, 12'o7402);
		loadWord(12'o050, 12'o4321);
		loadWord(12'o260, 12'o1300);
		loadWord(12'o1300, 12'o2222);
		loadWord(12'o010, 12'o2277);
		loadWord(12'o2300, 12'o1111);
		loadWord(12'o2301, 12'o0707);
		loadWord(12'o017, 12'o3377);
		loadWord(12'o261, 12'o1234);
		startCore();
		waitHalted("addressing", count);
		sum = 13'o4321 + 13'o2222 + 13'o1111 + 13'o0707;
		compareWord("auto-index store", memory_inst.mem[12'o3400], sum[11:0]);
		compareWord("pointer at 0o10", memory_inst.mem[12'o010], 12'o2301);
		compareWord("pointer at 0o17", memory_inst.mem[12'o017], 12'o3400);
		compareWord("word below first operand", memory_inst.mem[12'o2277], fillWord(12'o2277));
		compareWord("addressing acc", acc, 12'o1234);
		compareBit("addressing link", link, sum[12]);
	endtask

	task automatic testControlFlow(input int calls, input pdpWord_t step);
		logic [12:0] lac;
		int          n;
		int          count;
		beginProgram(WAIT_NORMAL);
		loadWord(12'o200, 12'o7300);
		loadWord(12'o201, 12'o4220);                // JMS 220
		loadWord(12'o202, 12'o2250);                // ISZ count
		loadWord(12'o203, 12'o5201);                // JMP 201
		loadWord(12'o204, 12'o7402);
		loadWord(12'o220, 12'o0000);                // Return slot
		loadWord(12'o221, 12'o1251);                // TAD step
		loadWord(12'o222, 12'o2252);                // Call counter
		loadWord(12'o223, 12'o5620);                // JMP I 220
		loadWord(12'o250, 12'o0 - pdpWord_t'(calls));
		loadWord(12'o251, step);
		loadWord(12'o252, 12'o0000);
		startCore();
		waitHalted("control flow", count);
		lac = '0;
		for (n = 0; n < calls; n++)
			lac = lac + {1'b0, step};
		compareWord("loop sum", acc, lac[11:0]);
		compareBit("loop link", link, lac[12]);
		compareWord("subroutine calls", memory_inst.mem[12'o252], pdpWord_t'(calls));
		compareWord("loop count word", memory_inst.mem[12'o250], 12'o0000);
		compareWord("JMS return slot", memory_inst.mem[12'o220], 12'o0202);
	endtask

	task automatic testGroup1();
		pdpWord_t    uops [0:13];
		logic [31:0] rnd;
		logic [12:0] expLac;
		int          i;
		int          count;
		uops = '{12'o7200, 12'o7100, 12'o7040, 12'o7020, 12'o7001, 12'o7041, 12'o7010,
		         12'o7004, 12'o7012, 12'o7006, 12'o7240, 12'o7241, 12'o7031, 12'o7325};
		for (i = 0; i < 14; i++) begin
			rnd = $random(seed);
			beginProgram(WAIT_NORMAL);
			loadMicroProgram(uops[i], rnd[11:0], rnd[20]);
			startCore();
			waitHalted("group 1", count);
			expLac = group1Expect(uops[i], rnd[11:0], rnd[20]);
			compareWord($sformatf("acc after %04o", uops[i]), acc, expLac[11:0]);
			compareBit($sformatf("link after %04o", uops[i]), link, expLac[12]);
		end
	endtask

	task automatic testGroup2();
		pdpWord_t    uops [0:13];
		logic [31:0] rnd;
		pdpWord_t    accIn;
		logic        skip;
		int          i;
		int          count;
		uops = '{12'o7500, 12'o7440, 12'o7420, 12'o7540, 12'o7560, 12'o7510, 12'o7450,
		         12'o7430, 12'o7550, 12'o7470, 12'o7410, 12'o7640, 12'o7604, 12'o7404};
		for (i = 0; i < 14; i++) begin
			rnd   = $random(seed);
			accIn = (i % 4 == 1) ? 12'o0000 : rnd[11:0];    // Zero often enough for SZA
			beginProgram(WAIT_NORMAL);
			switchReg = rnd[31:20];
			loadMicroProgram(uops[i], accIn, rnd[15]);
			startCore();
			waitHalted("group 2", count);
			skip = group2Skip(uops[i], accIn, rnd[15]);
			compareWord($sformatf("marker after %04o", uops[i]), memory_inst.mem[12'o252],
			            skip ? 12'o0000 : 12'o0001);
			compareWord($sformatf("acc after %04o", uops[i]), acc,
			            group2Acc(uops[i], accIn, rnd[31:20]));
			compareBit($sformatf("link after %04o", uops[i]), link, rnd[15]);
		end
	endtask

	// Same program with and without stalls, results checked each time
	task automatic testBackPressure();
		int slow;
		int fast;
		testArithmetic("long waits", WAIT_LONG, slow);
		testArithmetic("no waits", 0, fast);
		compareBit("long waits take longer", slow > fast, 1'b1);
		testControlFlow(9, 12'o0765);
	endtask

	//********************************************************************
	// Sequence
	//********************************************************************
	initial begin
		clk       = 1'b0;
		rst       = 1'b1;
		switchReg = '0;
		maxWait   = WAIT_NORMAL;
		seed      = SEED;
		checks    = 0;
		errors    = 0;
		timeouts  = 0;
		testReset();
		testArithmetic("arithmetic", WAIT_NORMAL, cycles);
		testAddressing();
		testControlFlow(7, 12'o1234);
		testGroup1();
		testGroup2();
		testBackPressure();
		$display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
verilog/pdpIsaPkg.sv
verilog/pdpBusPkg.sv
verilog/pdpApbMaster.sv
verilog/pdpFetch.sv
verilog/pdpAddrGen.sv
verilog/pdpMicroOps.sv
verilog/pdpExecute.sv
verilog/pdpCore.sv
dv/pdpApbMemory.sv
dv/pdpCoreTb.sv

// ==== Bender.yml ====
package:
  name: pdp_core

sources:
  - verilog/pdpIsaPkg.sv
  - verilog/pdpBusPkg.sv
  - verilog/pdpApbMaster.sv
  - verilog/pdpFetch.sv
  - verilog/pdpAddrGen.sv
  - verilog/pdpMicroOps.sv
  - verilog/pdpExecute.sv
  - verilog/pdpCore.sv
  - target: simulation
    files:
      - dv/pdpApbMemory.sv
      - dv/pdpCoreTb.sv
